// File: sources.f
verilog/mc_pkg.sv
verilog/mc_ctrl_if.sv
verilog/main_fsm.sv
verilog/alu_decoder.sv
verilog/control_unit.sv
verilog/reg_file.sv
verilog/datapath.sv
verilog/mc_core_top.sv
verification/mc_core_checker.sv
verification/mc_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the multicycle core testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module mc_core_tb \
    -o mc_core_sim > build.log 2>&1 \
    && ./obj_dir/mc_core_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -qx "Test passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL (see build.log and sim.log)"; exit 1; }

// File: verification/mc_core_tb.sv
// Memory is 1024 words, code below 0x800 and data above; programs end in a jal-to-self loop.
`timescale 1ns/1ps
`default_nettype none

module mc_core_tb
    import mc_pkg::*;
;
    localparam int          NTESTS     = 6;
    localparam int          CODE_WORDS = 512;
    localparam int          MAX_STEPS  = 4000;
    localparam int          CLK_PERIOD = 40;
    localparam logic [31:0] RESET_PC   = 32'h0;

    logic        clk;
    logic        arstn;
    logic [31:0] i_mem_rdata;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic        o_mem_we;

    logic [31:0] mem [1024];
    logic [31:0] stage [1024];
    logic [31:0] ref_mem [1024];
    logic [31:0] rf [32];
    logic [31:0] image [NTESTS][CODE_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       names [NTESTS];
    int          steps [NTESTS];
    int          store_idx;
    int          errors;
    int          passed;
    int          failed;
    int          cur;
    int          pos;
    int          st_off;
    realtime     wd_limit;

    mc_core_top #(
        .RESET_PC (RESET_PC)
    ) u_mc_core_top (
        .clk         (clk),
        .arstn       (arstn),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_we    (o_mem_we)
    );

    bind mc_core_top mc_core_checker u_checker (
        .clk        (clk),
        .arstn      (arstn),
        .i_mem_addr (o_mem_addr),
        .i_mem_we   (o_mem_we)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Memory model
    // ------------------------------
    assign i_mem_rdata = mem[o_mem_addr[11:2]];

    // The next program image is copied in while the core is held in reset.
    always @(posedge clk) begin
        if (!arstn) begin
            mem <= stage;
        end else if (o_mem_we) begin
            mem[o_mem_addr[11:2]] <= o_mem_wdata;
        end
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Each DUT store is matched against the next store of the ISA model.
    always @(posedge clk) begin
        if (arstn && o_mem_we) begin
            if (store_idx < exp_addr.size()) begin
                check_value("o_mem_addr", o_mem_addr, exp_addr[store_idx]);
                check_value("o_mem_wdata", o_mem_wdata, exp_data[store_idx]);
            end else begin
                $display("Store to 0x%h came after all expected stores", o_mem_addr);
                errors++;
            end
            store_idx++;
        end
    end

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic emit(logic [31:0] word);
        image[cur][pos] = word;
        pos++;
    endtask

    // Store a register to the next free word above the data base in x31.
    task automatic st(int rs);
        emit(enc_s(st_off, rs, 31));
        st_off += 4;
    endtask

    task automatic begin_prog(int t, string name);
        cur    = t;
        pos    = 0;
        st_off = 256;
        names[t] = name;
        for (int i = 0; i < CODE_WORDS; i++) begin
            image[t][i] = 32'h0;
        end
        // Data base 0x800 goes into x31.
        emit(enc_i(1024, 0, 0, 31, OP_I));
        emit(enc_r(0, 31, 31, 0, 31));
    endtask

    // ------------------------------
    // ISA reference model
    // ------------------------------
    function automatic int ref_run();
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic [2:0]  f3;
        logic        f3_ok;
        logic        wr;
        int          n;
        pc = RESET_PC;
        n  = 0;
        for (int r = 0; r < 32; r++) begin
            rf[r] = 32'h0;
        end
        exp_addr.delete();
        exp_data.delete();
        while (n < MAX_STEPS) begin
            ins = ref_mem[pc[11:2]];
            n++;
            if (ins == enc_j(0, 0)) begin
                break;
            end
            a     = rf[ins[19:15]];
            b     = rf[ins[24:20]];
            f3    = ins[14:12];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            f3_ok = (f3 == 3'b000) || (f3 == 3'b010) || (f3 == 3'b110) || (f3 == 3'b111);
            nxt   = pc + 32'd4;
            wr    = 1'b0;
            res   = 32'h0;
            if (ins[6:0] == OP_LOAD && f3 == 3'b010) begin
                addr = a + imm_i;
                res  = ref_mem[addr[11:2]];
                wr   = 1'b1;
            end else if (ins[6:0] == OP_STORE && f3 == 3'b010) begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                ref_mem[addr[11:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end else if ((ins[6:0] == OP_R || ins[6:0] == OP_I) && f3_ok) begin
                if (ins[6:0] == OP_I) begin
                    b = imm_i;
                end
                wr = (ins[6:0] == OP_I) || !ins[30] || (f3 == 3'b000);
                case (f3)
                    3'b000:  res = (ins[6:0] == OP_R && ins[30]) ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end else if (ins[6:0] == OP_BRANCH && f3 == 3'b000) begin
                if (a == b) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end else if (ins[6:0] == OP_JAL) begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            if (wr && ins[11:7] != 5'd0) begin
                rf[ins[11:7]] = res;
            end
            pc = nxt;
        end
        return n;
    endfunction

    // ------------------------------
    // Programs
    // ------------------------------
    task automatic build_programs();
        int kind;
        int sel;
        int rd;
        int rs1;
        int rs2;
        begin_prog(0, "reset and first store");
        emit(enc_i(32'h123, 0, 0, 1, OP_I));
        st(1);
        emit(enc_i(-1, 0, 0, 2, OP_I));
        st(2);
        emit(enc_j(0, 0));

        begin_prog(1, "R-type on loaded operands");
        emit(enc_i(0, 31, 2, 1, OP_LOAD));
        emit(enc_i(4, 31, 2, 2, OP_LOAD));
        emit(enc_i(-7, 0, 0, 3, OP_I));
        emit(enc_i(-7, 0, 0, 4, OP_I));
        emit(enc_i(9, 0, 0, 6, OP_I));
        emit(enc_r(0, 2, 1, 0, 5));
        st(5);
        emit(enc_r(32, 2, 1, 0, 5));
        st(5);
        emit(enc_r(0, 2, 1, 7, 5));
        st(5);
        emit(enc_r(0, 2, 1, 6, 5));
        st(5);
        emit(enc_r(0, 2, 1, 2, 5));
        st(5);
        emit(enc_r(32, 4, 3, 0, 5));
        st(5);
        emit(enc_r(0, 4, 3, 2, 5));
        st(5);
        emit(enc_r(0, 6, 3, 2, 5));
        st(5);
        emit(enc_r(0, 3, 6, 2, 5));
        st(5);
        emit(enc_j(0, 0));

        begin_prog(2, "I-type, load after store, x0");
        emit(enc_i(8, 31, 2, 1, OP_LOAD));
        emit(enc_i(-100, 1, 0, 2, OP_I));
        st(2);
        emit(enc_i(-16, 1, 7, 2, OP_I));
        st(2);
        emit(enc_i(-256, 1, 6, 2, OP_I));
        st(2);
        emit(enc_i(-5, 0, 0, 3, OP_I));
        emit(enc_i(-3, 3, 2, 2, OP_I));
        st(2);
        emit(enc_i(-9, 3, 2, 2, OP_I));
        st(2);
        emit(enc_s(64, 1, 31));
        emit(enc_i(64, 31, 2, 4, OP_LOAD));
        st(4);
        emit(enc_i(77, 0, 0, 0, OP_I));
        st(0);
        emit(enc_j(0, 0));

        begin_prog(3, "beq forward and backward");
        emit(enc_i(3, 0, 0, 1, OP_I));
        emit(enc_i(3, 0, 0, 2, OP_I));
        emit(enc_i(4, 0, 0, 3, OP_I));
        emit(enc_b(12, 2, 1));
        emit(enc_i(32'h11, 0, 0, 5, OP_I));
        st(5);
        emit(enc_i(32'h22, 0, 0, 5, OP_I));
        st(5);
        emit(enc_b(12, 3, 1));
        emit(enc_i(32'h33, 0, 0, 5, OP_I));
        st(5);
        emit(enc_i(3, 0, 0, 6, OP_I));
        emit(enc_i(-1, 6, 0, 6, OP_I));
        st(6);
        emit(enc_b(8, 0, 6));
        emit(enc_b(-12, 0, 0));
        emit(enc_j(0, 0));

        begin_prog(4, "jal link and unsupported opcodes");
        emit(enc_j(12, 1));
        emit(enc_i(32'h55, 0, 0, 7, OP_I));
        st(7);
        st(1);
        emit(enc_i(32'h66, 0, 0, 7, OP_I));
        st(7);
        // lui, jalr, fence and ecall words.
        emit(32'h12345437);
        emit(32'h000000e7);
        emit(32'h0000000f);
        emit(32'h00000073);
        st(8);
        st(1);
        emit(enc_j(0, 0));

        begin_prog(5, "random ALU, load and store");
        for (int k = 0; k < 200; k++) begin
            kind = int'($urandom % 10);
            sel  = int'($urandom % 5);
            rd   = 1 + int'($urandom % 15);
            rs1  = int'($urandom % 16);
            rs2  = int'($urandom % 16);
            if (kind < 2) begin
                emit(enc_i(int'($urandom % 256) * 4, 31, 2, rd, OP_LOAD));
            end else if (kind < 4) begin
                emit(enc_s(int'($urandom % 256) * 4, rs2, 31));
            end else if (kind < 7) begin
                case (sel)
                    0:       emit(enc_r(0, rs2, rs1, 0, rd));
                    1:       emit(enc_r(32, rs2, rs1, 0, rd));
                    2:       emit(enc_r(0, rs2, rs1, 7, rd));
                    3:       emit(enc_r(0, rs2, rs1, 6, rd));
                    default: emit(enc_r(0, rs2, rs1, 2, rd));
                endcase
            end else begin
                case (sel % 4)
                    0:       emit(enc_i(int'($urandom % 4096), rs1, 0, rd, OP_I));
                    1:       emit(enc_i(int'($urandom % 4096), rs1, 7, rd, OP_I));
                    2:       emit(enc_i(int'($urandom % 4096), rs1, 6, rd, OP_I));
                    default: emit(enc_i(int'($urandom % 4096), rs1, 2, rd, OP_I));
                endcase
            end
        end
        emit(enc_j(0, 0));
    endtask

    // Code from the image, data words from a pattern of the full address.
    task automatic load_test(int t);
        for (int i = 0; i < 1024; i++) begin
            if (i < CODE_WORDS) begin
                stage[i] = image[t][i];
            end else begin
                stage[i] = (32'(i * 4) * 32'h9e3779b9) ^ 32'h13572468;
            end
        end
        ref_mem = stage;
    endtask

    task automatic run_test(int t);
        int err0;
        int cycles;
        int limit;
        @(posedge clk);
        #1;
        err0  = errors;
        arstn = 1'b0;
        load_test(t);
        void'(ref_run());
        store_idx = 0;
        repeat (4) @(posedge clk);
        #1;
        arstn = 1'b1;
        check_value("o_mem_addr", o_mem_addr, RESET_PC);
        check_value("o_mem_we", {31'd0, o_mem_we}, 32'h0);
        cycles = 0;
        limit  = steps[t] * 5 + 20;
        while (store_idx < exp_addr.size() && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (store_idx < exp_addr.size()) begin
            $display("Test %0d stopped after %0d of %0d stores", t, store_idx, exp_addr.size());
            errors++;
        end
        if (errors == err0) begin
            passed++;
            $display("test %0d (%s): ok, %0d stores", t, names[t], exp_addr.size());
        end else begin
            failed++;
            $display("test %0d (%s): FAILED", t, names[t]);
        end
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        int total;
        arstn     = 1'b0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        store_idx = 0;
        wd_limit  = 0;
        total     = 0;
        void'($urandom(32'h3ec07856));
        build_programs();
        for (int t = 0; t < NTESTS; t++) begin
            load_test(t);
            steps[t] = ref_run();
            total += steps[t];
        end
        wd_limit = 1.5 * ((total * 5 + NTESTS * 8) * CLK_PERIOD);
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, tests failed: %0d, errors: %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (wd_limit > 0);
        #(wd_limit);
        $display("The run timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/mc_core_checker.sv
// Bound to mc_core_top; checks hold only while arstn is high.
`timescale 1ns/1ps
`default_nettype none

module mc_core_checker (
    input logic        clk,
    input logic        arstn,
    input logic [31:0] i_mem_addr,
    input logic        i_mem_we
);
    // ------------------------------
    // Memory port rules
    // ------------------------------

    // Stores are word accesses only.
    a_we_aligned : assert property (
        @(posedge clk) disable iff (!arstn)
        i_mem_we |-> (i_mem_addr[1:0] == 2'b00)
    ) else $error("store to an address that is not word aligned");

    // A store lasts one state and never follows another.
    a_we_single : assert property (
        @(posedge clk) disable iff (!arstn)
        i_mem_we |=> !i_mem_we
    ) else $error("write enable high on two cycles in a row");

    a_addr_known : assert property (
        @(posedge clk) disable iff (!arstn)
        !$isunknown(i_mem_addr)
    ) else $error("memory address has unknown bits");

endmodule

`default_nettype wire

// File: verilog/mc_core_top.sv
// Multicycle RV32I core top; unified memory outside, combinational read, write on o_mem_we edge.
`timescale 1ns/1ps
`default_nettype none

module mc_core_top
    import mc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0
)
(
    input  logic            clk,
    input  logic            arstn,
    input  logic [XLEN-1:0] i_mem_rdata,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output logic            o_mem_we
);
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            rd_we;
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;

    mc_ctrl_if u_ctrl_if ();

    control_unit u_control_unit (
        .clk   (clk),
        .arstn (arstn),
        .bus   (u_ctrl_if.ctrl)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk         (clk),
        .arstn       (arstn),
        .i_mem_rdata (i_mem_rdata),
        .i_rdata1    (rdata1),
        .i_rdata2    (rdata2),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_rd_we     (rd_we),
        .o_rd_wdata  (rd_wdata),
        .bus         (u_ctrl_if.dp)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arstn    (arstn),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_we     (rd_we),
        .i_rd     (rd),
        .i_wdata  (rd_wdata),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    assign o_mem_we = u_ctrl_if.mem_write_en;

endmodule

`default_nettype wire

// File: verilog/datapath.sv
// Multicycle datapath; memory must answer reads in the same cycle, word accesses only.
`timescale 1ns/1ps
`default_nettype none

module datapath
    import mc_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
)
(
    input  logic            clk,
    input  logic            arstn,
    input  logic [XLEN-1:0] i_mem_rdata,
    input  logic [XLEN-1:0] i_rdata1,
    input  logic [XLEN-1:0] i_rdata2,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output logic [4:0]      o_rs1,
    output logic [4:0]      o_rs2,
    output logic [4:0]      o_rd,
    output logic            o_rd_we,
    output logic [XLEN-1:0] o_rd_wdata,
    mc_ctrl_if.dp           bus
);
    t_instr          instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] old_pc;
    logic [XLEN-1:0] data_reg;
    logic [XLEN-1:0] a_reg;
    logic [XLEN-1:0] b_reg;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;
    logic            zero;

    // ------------------------------
    // Architectural registers
    // ------------------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            pc    <= RESET_PC;
            instr <= '0;
        end else begin
            // Taken branch when rs1 - rs2 is zero.
            if (bus.pc_update || (bus.branch && zero)) begin
                pc <= result;
            end
            if (bus.instr_write_en) begin
                instr <= i_mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.instr_write_en) begin
            old_pc <= pc;
        end
        data_reg <= i_mem_rdata;
        a_reg    <= i_rdata1;
        b_reg    <= i_rdata2;
        alu_out  <= alu_result;
    end

    // Fields toward control and register file.
    assign bus.op       = instr.r.opcode;
    assign bus.funct3   = instr.r.funct3;
    assign bus.funct7_5 = instr.r.funct7[5];
    assign o_rs1        = instr.r.rs1;
    assign o_rs2        = instr.r.rs2;
    assign o_rd         = instr.r.rd;

    // Immediate extension.
    always_comb begin
        case (instr.r.opcode)
            OP_STORE:  imm_ext = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            OP_BRANCH: imm_ext = {{20{instr.b.imm_12}}, instr.b.imm_11,
                                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            OP_JAL:    imm_ext = {{12{instr.j.imm_20}}, instr.j.imm_19_12,
                                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            default:   imm_ext = {{20{instr.i.imm[11]}}, instr.i.imm};
        endcase
    end

    // ------------------------------
    // ALU and muxes
    // ------------------------------
    always_comb begin
        case (bus.alu_src_a)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            SRC_A_RS1:    src_a = a_reg;
            default:      src_a = '0;
        endcase
        case (bus.alu_src_b)
            SRC_B_RS2:  src_b = b_reg;
            SRC_B_IMM:  src_b = imm_ext;
            SRC_B_FOUR: src_b = 32'd4;
            default:    src_b = '0;
        endcase
    end

    always_comb begin
        case (bus.alu_ctrl)
            ALU_SUB: alu_result = src_a - src_b;
            ALU_AND: alu_result = src_a & src_b;
            ALU_OR:  alu_result = src_a | src_b;
            ALU_SLT: alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
            default: alu_result = src_a + src_b;
        endcase
    end

    assign zero = (alu_result == '0);

    always_comb begin
        case (bus.result_src)
            RES_DATA: result = data_reg;
            RES_ALU:  result = alu_result;
            default:  result = alu_out;
        endcase
    end

    assign o_mem_addr  = bus.mem_addr_src ? alu_out : pc;
    assign o_mem_wdata = b_reg;
    assign o_rd_we     = bus.reg_write_en;
    assign o_rd_wdata  = result;

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
// 32x32 register file, combinational read and edge write; x0 is hard-wired to zero.
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import mc_pkg::*;
(
    input  logic            clk,
    input  logic            arstn,
    input  logic [4:0]      i_rs1,
    input  logic [4:0]      i_rs2,
    input  logic            i_we,
    input  logic [4:0]      i_rd,
    input  logic [XLEN-1:0] i_wdata,
    output logic [XLEN-1:0] o_rdata1,
    output logic [XLEN-1:0] o_rdata2
);
    // No storage for x0.
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
// Control unit of the multicycle core; outputs settle within the cycle of each state.
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import mc_pkg::*;
(
    input  logic    clk,
    input  logic    arstn,
    mc_ctrl_if.ctrl bus
);
    t_alu_op alu_op;

    main_fsm u_main_fsm (
        .clk              (clk),
        .arstn            (arstn),
        .i_op             (bus.op),
        .i_func_3         (bus.funct3),
        .i_func_7_5       (bus.funct7_5),
        .o_alu_op         (alu_op),
        .o_result_src     (bus.result_src),
        .o_alu_src_1      (bus.alu_src_a),
        .o_alu_src_2      (bus.alu_src_b),
        .o_mem_addr_src   (bus.mem_addr_src),
        .o_reg_write_en   (bus.reg_write_en),
        .o_pc_update      (bus.pc_update),
        .o_mem_write_en   (bus.mem_write_en),
        .o_instr_write_en (bus.instr_write_en),
        .o_branch         (bus.branch)
    );

    alu_decoder u_alu_decoder (
        .i_alu_op   (alu_op),
        .i_func_3   (bus.funct3),
        .i_func_7_5 (bus.funct7_5),
        .i_op_5     (bus.op[5]),
        .o_alu_ctrl (bus.alu_ctrl)
    );

endmodule

`default_nettype wire

// File: verilog/alu_decoder.sv
// ALU function decode for the RV32I subset; unknown funct3 values fall back to add.
`timescale 1ns/1ps
`default_nettype none

module alu_decoder
    import mc_pkg::*;
(
    input  t_alu_op   i_alu_op,
    input  logic [2:0] i_func_3,
    input  logic      i_func_7_5,
    input  logic      i_op_5,
    output t_alu_ctrl o_alu_ctrl
);
    always_comb begin
        case (i_alu_op)
            ALU_OP_ADD: o_alu_ctrl = ALU_ADD;
            ALU_OP_SUB: o_alu_ctrl = ALU_SUB;
            default: begin
                case (i_func_3)
                    // Immediate forms have no sub, so bit 5 of the opcode gates it.
                    3'b000:  o_alu_ctrl = (i_op_5 && i_func_7_5) ? ALU_SUB : ALU_ADD;
                    3'b010:  o_alu_ctrl = ALU_SLT;
                    3'b110:  o_alu_ctrl = ALU_OR;
                    3'b111:  o_alu_ctrl = ALU_AND;
                    default: o_alu_ctrl = ALU_ADD;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/main_fsm.sv
// Multicycle sequencer; unsupported opcodes and function codes return to FETCH as no-ops.
`timescale 1ns/1ps
`default_nettype none

module main_fsm
    import mc_pkg::*;
(
    input  logic        clk,
    input  logic        arstn,

    input  logic [6:0]  i_op,
    input  logic [2:0]  i_func_3,
    input  logic        i_func_7_5,

    output t_alu_op     o_alu_op,
    output t_result_src o_result_src,
    output t_src_a      o_alu_src_1,
    output t_src_b      o_alu_src_2,
    output logic        o_mem_addr_src,
    output logic        o_reg_write_en,
    output logic        o_pc_update,
    output logic        o_mem_write_en,
    output logic        o_instr_write_en,
    output logic        o_branch
);
    typedef enum logic [3:0] {
        FETCH, DECODE, MEMADDR, MEMREAD, MEMWB, MEMWRITE,
        EXECUTER, EXECUTEI, ALUWB, JAL, BRANCH
    } t_state;

    typedef enum logic [2:0] {
        CL_NONE, CL_LOAD, CL_STORE, CL_R, CL_I, CL_BRANCH, CL_JAL
    } t_class;

    t_state state;
    t_state next_state;
    t_class instr_class;
    logic   alu_f3_ok;

    // Only add, slt, or, and exist; funct7 bit 5 is legal only for sub.
    assign alu_f3_ok = (i_func_3 == 3'b000) || (i_func_3 == 3'b010) ||
                       (i_func_3 == 3'b110) || (i_func_3 == 3'b111);

    always_comb begin
        instr_class = CL_NONE;
        case (i_op)
            OP_LOAD:   if (i_func_3 == 3'b010) instr_class = CL_LOAD;
            OP_STORE:  if (i_func_3 == 3'b010) instr_class = CL_STORE;
            OP_R: begin
                if (alu_f3_ok && (!i_func_7_5 || i_func_3 == 3'b000)) begin
                    instr_class = CL_R;
                end
            end
            OP_I:      if (alu_f3_ok) instr_class = CL_I;
            OP_BRANCH: if (i_func_3 == 3'b000) instr_class = CL_BRANCH;
            OP_JAL:    instr_class = CL_JAL;
            default:   instr_class = CL_NONE;
        endcase
    end

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH: next_state = DECODE;
            DECODE: begin
                case (instr_class)
                    CL_LOAD, CL_STORE: next_state = MEMADDR;
                    CL_R:              next_state = EXECUTER;
                    CL_I:              next_state = EXECUTEI;
                    CL_BRANCH:         next_state = BRANCH;
                    CL_JAL:            next_state = JAL;
                    default:           next_state = FETCH;
                endcase
            end
            MEMADDR:  next_state = (instr_class == CL_LOAD) ? MEMREAD : MEMWRITE;
            MEMREAD:  next_state = MEMWB;
            EXECUTER: next_state = ALUWB;
            EXECUTEI: next_state = ALUWB;
            JAL:      next_state = ALUWB;
            default:  next_state = FETCH;
        endcase
    end

    // ------------------------------
    // Control levels per state
    // ------------------------------
    always_comb begin
        o_alu_op         = ALU_OP_ADD;
        o_result_src     = RES_ALU_OUT;
        o_alu_src_1      = SRC_A_PC;
        o_alu_src_2      = SRC_B_RS2;
        o_mem_addr_src   = 1'b0;
        o_reg_write_en   = 1'b0;
        o_pc_update      = 1'b0;
        o_mem_write_en   = 1'b0;
        o_instr_write_en = 1'b0;
        o_branch         = 1'b0;

        case (state)
            FETCH: begin
                // PC + 4 goes straight back into the PC.
                o_instr_write_en = 1'b1;
                o_alu_src_2      = SRC_B_FOUR;
                o_result_src     = RES_ALU;
                o_pc_update      = 1'b1;
            end
            DECODE: begin
                // Branch or jump target, held in the ALU output register.
                o_alu_src_1 = SRC_A_OLD_PC;
                o_alu_src_2 = SRC_B_IMM;
            end
            MEMADDR: begin
                o_alu_src_1 = SRC_A_RS1;
                o_alu_src_2 = SRC_B_IMM;
            end
            MEMREAD: o_mem_addr_src = 1'b1;
            MEMWB: begin
                o_result_src   = RES_DATA;
                o_reg_write_en = 1'b1;
            end
            MEMWRITE: begin
                o_mem_addr_src = 1'b1;
                o_mem_write_en = 1'b1;
            end
            EXECUTER: begin
                o_alu_src_1 = SRC_A_RS1;
                o_alu_op    = ALU_OP_FUNC;
            end
            EXECUTEI: begin
                o_alu_src_1 = SRC_A_RS1;
                o_alu_src_2 = SRC_B_IMM;
                o_alu_op    = ALU_OP_FUNC;
            end
            ALUWB: o_reg_write_en = 1'b1;
            JAL: begin
                // Link value computed while the PC takes the target.
                o_alu_src_1 = SRC_A_OLD_PC;
                o_alu_src_2 = SRC_B_FOUR;
                o_pc_update = 1'b1;
            end
            BRANCH: begin
                o_alu_src_1 = SRC_A_RS1;
                o_alu_op    = ALU_OP_SUB;
                o_branch    = 1'b1;
            end
            default: o_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mc_ctrl_if.sv
// Control bundle between datapath and control unit; all signals are levels, no handshake.
`timescale 1ns/1ps
`default_nettype none

interface mc_ctrl_if
    import mc_pkg::*;
();
    // Fields from the instruction register.
    logic [6:0]  op;
    logic [2:0]  funct3;
    logic        funct7_5;

    // Control levels.
    t_src_a      alu_src_a;
    t_src_b      alu_src_b;
    t_alu_ctrl   alu_ctrl;
    t_result_src result_src;
    logic        mem_addr_src;
    logic        reg_write_en;
    logic        pc_update;
    logic        instr_write_en;
    logic        branch;
    logic        mem_write_en;

    modport dp (
        output op, funct3, funct7_5,
        input  alu_src_a, alu_src_b, alu_ctrl, result_src, mem_addr_src,
        input  reg_write_en, pc_update, instr_write_en, branch, mem_write_en
    );

    modport ctrl (
        input  op, funct3, funct7_5,
        output alu_src_a, alu_src_b, alu_ctrl, result_src, mem_addr_src,
        output reg_write_en, pc_update, instr_write_en, branch, mem_write_en
    );

endinterface

`default_nettype wire

// File: verilog/mc_pkg.sv
// RV32I subset only; XLEN is fixed at 32 and encodings cover lw, sw, beq, jal and basic ALU ops.
`default_nettype none

package mc_pkg;

    localparam int XLEN = 32;

    // ------------------------------
    // Control encodings
    // ------------------------------
    typedef enum logic [1:0] {
        ALU_OP_ADD  = 2'b00,
        ALU_OP_SUB  = 2'b01,
        ALU_OP_FUNC = 2'b10
    } t_alu_op;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } t_alu_ctrl;

    typedef enum logic [1:0] {
        SRC_A_PC     = 2'b00,
        SRC_A_OLD_PC = 2'b01,
        SRC_A_RS1    = 2'b10
    } t_src_a;

    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'b00,
        SRC_B_IMM  = 2'b01,
        SRC_B_FOUR = 2'b10
    } t_src_b;

    // ALU_OUT is the registered ALU result, ALU the live one.
    typedef enum logic [1:0] {
        RES_ALU_OUT = 2'b00,
        RES_DATA    = 2'b01,
        RES_ALU     = 2'b10
    } t_result_src;

    // ------------------------------
    // Instruction word formats
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_instr_r;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } t_instr_i;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } t_instr_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } t_instr_b;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } t_instr_j;

    typedef union packed {
        t_instr_r r;
        t_instr_i i;
        t_instr_s s;
        t_instr_b b;
        t_instr_j j;
    } t_instr;

    // Supported opcodes.
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

endpackage

`default_nettype wire
